/* core_config.svh */
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// datapath width, RV32
`define XLEN 32

// architectural register file
`define NUM_REGS 32
`define REG_ADDR_W 5

// fetch starts here after reset
`define RESET_PC 32'h0000_0000

// bytes per data word, one store enable each
`define NUM_BYTE_LANES 4

`endif

/* rv_isa_pkg.sv */
`include "core_config.svh"

package rv_isa_pkg;

  typedef logic [`XLEN-1:0] word_t;
  typedef logic [`REG_ADDR_W-1:0] reg_addr_t;
  typedef logic [`NUM_BYTE_LANES-1:0] byte_en_t;
  typedef logic [2:0] funct3_t;

  // major opcodes, base integer set only
  typedef enum logic [6:0] {
    opc_load     = 7'b000_0011,
    opc_misc_mem = 7'b000_1111,
    opc_op_imm   = 7'b001_0011,
    opc_auipc    = 7'b001_0111,
    opc_store    = 7'b010_0011,
    opc_op       = 7'b011_0011,
    opc_lui      = 7'b011_0111,
    opc_branch   = 7'b110_0011,
    opc_jalr     = 7'b110_0111,
    opc_jal      = 7'b110_1111,
    opc_system   = 7'b111_0011
  } opcode_e;

  // funct3 of op and op_imm
  localparam funct3_t f3_add_sub = 3'b000;
  localparam funct3_t f3_sll     = 3'b001;
  localparam funct3_t f3_slt     = 3'b010;
  localparam funct3_t f3_sltu    = 3'b011;
  localparam funct3_t f3_xor     = 3'b100;
  localparam funct3_t f3_srl_sra = 3'b101;
  localparam funct3_t f3_or      = 3'b110;
  localparam funct3_t f3_and     = 3'b111;

  // funct3 of branch
  localparam funct3_t f3_beq  = 3'b000;
  localparam funct3_t f3_bne  = 3'b001;
  localparam funct3_t f3_blt  = 3'b100;
  localparam funct3_t f3_bge  = 3'b101;
  localparam funct3_t f3_bltu = 3'b110;
  localparam funct3_t f3_bgeu = 3'b111;

endpackage

/* core_pkg.sv */
package core_pkg;

  typedef enum logic [3:0] {
    alu_add,
    alu_sub,
    alu_sll,
    alu_slt,
    alu_sltu,
    alu_xor,
    alu_srl,
    alu_sra,
    alu_or,
    alu_and,
    alu_pass_b
  } alu_op_e;

  // source of the register write-back value
  typedef enum logic [1:0] {
    wb_alu,
    wb_load,
    wb_pc_plus4
  } wb_sel_e;

  // never for straight-line code, always for jal
  typedef enum logic [2:0] {
    br_never,
    br_eq,
    br_ne,
    br_lt,
    br_ge,
    br_ltu,
    br_geu,
    br_always
  } br_cond_e;

  typedef enum logic [1:0] {
    size_byte,
    size_half,
    size_word
  } mem_size_e;

endpackage

/* reg_file.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module reg_file
  import rv_isa_pkg::*;
(
  input  logic      clk,
  input  logic      rst,
  input  logic      we,
  input  reg_addr_t rs1_addr,
  input  reg_addr_t rs2_addr,
  input  reg_addr_t rd_addr,
  input  word_t     rd_data,
  output word_t     rs1_data,
  output word_t     rs2_data
);

  word_t regs [`NUM_REGS];

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 is hardwired
  assign rs1_data = (rs1_addr == '0) ? '0 : regs[rs1_addr];
  assign rs2_data = (rs2_addr == '0) ? '0 : regs[rs2_addr];

endmodule

/* insn_decoder.sv */
`timescale 1ns/1ns

module insn_decoder
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  word_t     insn,
  output reg_addr_t rs1_addr,
  output reg_addr_t rs2_addr,
  output reg_addr_t rd_addr,
  output word_t     imm,
  output alu_op_e   alu_op,
  output logic      alu_a_is_pc,
  output logic      alu_b_is_imm,
  output wb_sel_e   wb_sel,
  output logic      reg_we,
  output mem_size_e mem_size,
  output logic      load_unsigned,
  output logic      is_store,
  output br_cond_e  br_cond,
  output logic      is_jalr,
  output logic      halt
);

  opcode_e    opcode;
  funct3_t    funct3;
  logic [6:0] funct7;
  logic       f7_zero;
  logic       f7_alt;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_u;
  word_t      imm_j;

  assign opcode   = opcode_e'(insn[6:0]);
  assign rd_addr  = insn[11:7];
  assign funct3   = insn[14:12];
  assign rs1_addr = insn[19:15];
  assign rs2_addr = insn[24:20];
  assign funct7   = insn[31:25];
  assign f7_zero  = (funct7 == 7'b000_0000);
  assign f7_alt   = (funct7 == 7'b010_0000);

  // all immediates sign-extend from bit 31
  assign imm_i = {{20{insn[31]}}, insn[31:20]};
  assign imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  assign imm_b = {{20{insn[31]}}, insn[7], insn[30:25], insn[11:8], 1'b0};
  assign imm_u = {insn[31:12], 12'b0};
  assign imm_j = {{12{insn[31]}}, insn[19:12], insn[20], insn[30:21], 1'b0};

  // lb lh lw lbu lhu
  assign load_unsigned = funct3[2];

  always_comb begin
    imm          = imm_i;
    alu_op       = alu_add;
    alu_a_is_pc  = 1'b0;
    alu_b_is_imm = 1'b0;
    wb_sel       = wb_alu;
    reg_we       = 1'b0;
    mem_size     = funct3[1] ? size_word : (funct3[0] ? size_half : size_byte);
    is_store     = 1'b0;
    br_cond      = br_never;
    is_jalr      = 1'b0;
    halt         = 1'b0;

    case (opcode)
      opc_lui: begin
        imm          = imm_u;
        alu_op       = alu_pass_b;
        alu_b_is_imm = 1'b1;
        reg_we       = 1'b1;
      end
      opc_auipc: begin
        imm          = imm_u;
        alu_a_is_pc  = 1'b1;
        alu_b_is_imm = 1'b1;
        reg_we       = 1'b1;
      end
      opc_op_imm, opc_op: begin
        alu_b_is_imm = (opcode == opc_op_imm);
        case (funct3)
          f3_add_sub: alu_op = (opcode == opc_op && f7_alt) ? alu_sub : alu_add;
          f3_sll:     alu_op = alu_sll;
          f3_slt:     alu_op = alu_slt;
          f3_sltu:    alu_op = alu_sltu;
          f3_xor:     alu_op = alu_xor;
          f3_srl_sra: alu_op = f7_alt ? alu_sra : alu_srl;
          f3_or:      alu_op = alu_or;
          default:    alu_op = alu_and;
        endcase
        // funct7 only matters for shifts, and for add/sub in reg-reg form
        if (opcode == opc_op) begin
          reg_we = f7_zero || (f7_alt && (funct3 == f3_add_sub || funct3 == f3_srl_sra));
        end else if (funct3 == f3_sll) begin
          reg_we = f7_zero;
        end else if (funct3 == f3_srl_sra) begin
          reg_we = f7_zero || f7_alt;
        end else begin
          reg_we = 1'b1;
        end
      end
      opc_load: begin
        alu_b_is_imm = 1'b1;
        wb_sel       = wb_load;
        reg_we       = (funct3[1:0] != 2'b11) && !(funct3[2] && funct3[1]);
      end
      opc_store: begin
        imm          = imm_s;
        alu_b_is_imm = 1'b1;
        is_store     = !funct3[2] && (funct3[1:0] != 2'b11);
      end
      opc_branch: begin
        imm = imm_b;
        case (funct3)
          f3_beq:  br_cond = br_eq;
          f3_bne:  br_cond = br_ne;
          f3_blt:  br_cond = br_lt;
          f3_bge:  br_cond = br_ge;
          f3_bltu: br_cond = br_ltu;
          f3_bgeu: br_cond = br_geu;
          default: br_cond = br_never;
        endcase
      end
      opc_jal: begin
        imm     = imm_j;
        br_cond = br_always;
        wb_sel  = wb_pc_plus4;
        reg_we  = 1'b1;
      end
      opc_jalr: begin
        wb_sel  = wb_pc_plus4;
        is_jalr = (funct3 == 3'b000);
        reg_we  = (funct3 == 3'b000);
      end
      opc_system: begin
        // ecall only, everything else in the system space is ignored
        halt = (insn[31:7] == '0);
      end
      default: begin
        // fence and unknown opcodes keep the defaults
      end
    endcase
  end

endmodule

/* alu.sv */
`timescale 1ns/1ns

module alu
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  word_t   a,
  input  word_t   b,
  input  alu_op_e op,
  output word_t   result
);

  logic [4:0] shamt;

  // shifts use the low 5 bits only
  assign shamt = b[4:0];

  always_comb begin
    case (op)
      alu_add:    result = a + b;
      alu_sub:    result = a - b;
      alu_sll:    result = a << shamt;
      alu_slt:    result = word_t'($signed(a) < $signed(b));
      alu_sltu:   result = word_t'(a < b);
      alu_xor:    result = a ^ b;
      alu_srl:    result = a >> shamt;
      alu_sra:    result = word_t'($signed(a) >>> shamt);
      alu_or:     result = a | b;
      alu_and:    result = a & b;
      alu_pass_b: result = b;
      default:    result = '0;
    endcase
  end

endmodule

/* lsu_align.sv */
`timescale 1ns/1ns

module lsu_align
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  word_t     addr,
  input  word_t     store_value,
  input  word_t     load_word,
  input  mem_size_e size,
  input  logic      load_unsigned,
  input  logic      is_store,
  output word_t     dmem_addr,
  output word_t     store_data,
  output byte_en_t  store_we,
  output word_t     load_value
);

  logic [1:0] lane;
  byte_en_t   lane_mask;
  word_t      load_shifted;
  logic       ext;

  // memory sees whole words only
  assign dmem_addr = addr & ~word_t'(3);

  // first byte lane of the access, halves sit on 2-byte boundaries
  always_comb begin
    case (size)
      size_byte: begin
        lane      = addr[1:0];
        lane_mask = 4'b0001;
      end
      size_half: begin
        lane      = {addr[1], 1'b0};
        lane_mask = 4'b0011;
      end
      default: begin
        lane      = 2'b00;
        lane_mask = 4'b1111;
      end
    endcase
  end

  assign store_data = store_value << {lane, 3'b000};
  assign store_we   = is_store ? byte_en_t'(lane_mask << lane) : '0;

  assign load_shifted = load_word >> {lane, 3'b000};

  always_comb begin
    case (size)
      size_byte: begin
        ext        = !load_unsigned && load_shifted[7];
        load_value = {{24{ext}}, load_shifted[7:0]};
      end
      size_half: begin
        ext        = !load_unsigned && load_shifted[15];
        load_value = {{16{ext}}, load_shifted[15:0]};
      end
      default: begin
        ext        = 1'b0;
        load_value = load_word;
      end
    endcase
  end

endmodule

/* pc_unit.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module pc_unit
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  word_t    rs1_data,
  input  word_t    rs2_data,
  input  word_t    imm,
  input  br_cond_e br_cond,
  input  logic     is_jalr,
  output word_t    pc,
  output word_t    pc_plus4
);

  logic  taken;
  word_t next_pc;

  always_comb begin
    case (br_cond)
      br_eq:     taken = (rs1_data == rs2_data);
      br_ne:     taken = (rs1_data != rs2_data);
      br_lt:     taken = ($signed(rs1_data) < $signed(rs2_data));
      br_ge:     taken = ($signed(rs1_data) >= $signed(rs2_data));
      br_ltu:    taken = (rs1_data < rs2_data);
      br_geu:    taken = (rs1_data >= rs2_data);
      br_always: taken = 1'b1;
      default:   taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + word_t'(4);

  always_comb begin
    if (is_jalr) begin
      // target lsb is dropped for jalr
      next_pc = (rs1_data + imm) & ~word_t'(1);
    end else if (taken) begin
      next_pc = pc + imm;
    end else begin
      next_pc = pc_plus4;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= `RESET_PC;
    end else begin
      pc <= next_pc;
    end
  end

endmodule

/* rv_core.sv */
`timescale 1ns/1ns

module rv_core
  import rv_isa_pkg::*;
  import core_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  output logic     halt,
  output word_t    pc_to_imem,
  input  word_t    insn_from_imem,
  output word_t    addr_to_dmem,
  output word_t    store_data_to_dmem,
  input  word_t    load_data_from_dmem,
  output byte_en_t store_we_to_dmem
);

  reg_addr_t rs1_addr;
  reg_addr_t rs2_addr;
  reg_addr_t rd_addr;
  word_t     imm;
  alu_op_e   alu_op;
  logic      alu_a_is_pc;
  logic      alu_b_is_imm;
  wb_sel_e   wb_sel;
  logic      reg_we;
  mem_size_e mem_size;
  logic      load_unsigned;
  logic      is_store;
  br_cond_e  br_cond;
  logic      is_jalr;
  word_t     rs1_data;
  word_t     rs2_data;
  word_t     alu_a;
  word_t     alu_b;
  word_t     alu_result;
  word_t     load_value;
  word_t     pc_plus4;
  word_t     wb_data;

  insn_decoder u_decoder (
    .insn          (insn_from_imem),
    .rs1_addr      (rs1_addr),
    .rs2_addr      (rs2_addr),
    .rd_addr       (rd_addr),
    .imm           (imm),
    .alu_op        (alu_op),
    .alu_a_is_pc   (alu_a_is_pc),
    .alu_b_is_imm  (alu_b_is_imm),
    .wb_sel        (wb_sel),
    .reg_we        (reg_we),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .is_store      (is_store),
    .br_cond       (br_cond),
    .is_jalr       (is_jalr),
    .halt          (halt)
  );

  reg_file u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .we       (reg_we),
    .rs1_addr (rs1_addr),
    .rs2_addr (rs2_addr),
    .rd_addr  (rd_addr),
    .rd_data  (wb_data),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  // pc operand for auipc only
  assign alu_a = alu_a_is_pc ? pc_to_imem : rs1_data;
  assign alu_b = alu_b_is_imm ? imm : rs2_data;

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .op     (alu_op),
    .result (alu_result)
  );

  // alu sum doubles as the load/store address
  lsu_align u_lsu_align (
    .addr          (alu_result),
    .store_value   (rs2_data),
    .load_word     (load_data_from_dmem),
    .size          (mem_size),
    .load_unsigned (load_unsigned),
    .is_store      (is_store),
    .dmem_addr     (addr_to_dmem),
    .store_data    (store_data_to_dmem),
    .store_we      (store_we_to_dmem),
    .load_value    (load_value)
  );

  pc_unit u_pc_unit (
    .clk      (clk),
    .rst      (rst),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .imm      (imm),
    .br_cond  (br_cond),
    .is_jalr  (is_jalr),
    .pc       (pc_to_imem),
    .pc_plus4 (pc_plus4)
  );

  always_comb begin
    case (wb_sel)
      wb_load:     wb_data = load_value;
      wb_pc_plus4: wb_data = pc_plus4;
      default:     wb_data = alu_result;
    endcase
  end

endmodule

/* tb_rv_model.svh */
`ifndef TB_RV_MODEL_SVH
`define TB_RV_MODEL_SVH

// major opcodes of the base ISA
localparam logic [6:0] code_load   = 7'b000_0011;
localparam logic [6:0] code_op_imm = 7'b001_0011;
localparam logic [6:0] code_auipc  = 7'b001_0111;
localparam logic [6:0] code_store  = 7'b010_0011;
localparam logic [6:0] code_op     = 7'b011_0011;
localparam logic [6:0] code_lui    = 7'b011_0111;
localparam logic [6:0] code_branch = 7'b110_0011;
localparam logic [6:0] code_jalr   = 7'b110_0111;
localparam logic [6:0] code_jal    = 7'b110_1111;
localparam logic [6:0] code_system = 7'b111_0011;

// architectural state of the reference
word_t    model_regs [`NUM_REGS];
word_t    model_pc;
word_t    model_mem [64];

// expected outputs of the instruction in flight
word_t    exp_next_pc;
byte_en_t exp_we;
word_t    exp_addr;
word_t    exp_data;
logic     exp_halt;

// initial memory contents, different for every word
function automatic word_t fill_word(input int idx);
  return (word_t'(idx) * 32'h9e37_79b9) ^ 32'h3c6e_f372;
endfunction

function automatic word_t alu_result_of(input logic [2:0] f3, input logic alt,
                                        input word_t a, input word_t b);
  logic signed [31:0] sa;
  sa = a;
  case (f3)
    3'b000: return alt ? a - b : a + b;
    3'b001: return a << b[4:0];
    3'b010: return {31'b0, sa < $signed(b)};
    3'b011: return {31'b0, a < b};
    3'b100: return a ^ b;
    3'b101: begin
      if (alt) return sa >>> b[4:0];
      else return a >> b[4:0];
    end
    3'b110: return a | b;
    default: return a & b;
  endcase
endfunction

// one instruction against the model, sets the exp_* values
task automatic execute_insn(input word_t insn);
  word_t      a;
  word_t      b;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      addr;
  word_t      word;
  word_t      rd_val;
  logic [2:0] f3;
  logic [4:0] rd;
  logic       wr;
  logic       taken;
  f3 = insn[14:12];
  rd = insn[11:7];
  a = model_regs[insn[19:15]];
  b = model_regs[insn[24:20]];
  imm_i = {{20{insn[31]}}, insn[31:20]};
  imm_s = {{20{insn[31]}}, insn[31:25], insn[11:7]};
  imm_b = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
  imm_j = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
  wr = 1'b1;
  rd_val = '0;
  taken = 1'b0;
  exp_we = '0;
  exp_addr = '0;
  exp_data = '0;
  exp_halt = 1'b0;
  exp_next_pc = model_pc + 32'd4;
  case (insn[6:0])
    code_lui:    rd_val = {insn[31:12], 12'b0};
    code_auipc:  rd_val = model_pc + {insn[31:12], 12'b0};
    code_op_imm: rd_val = alu_result_of(f3, insn[30] && f3 == 3'b101, a, imm_i);
    code_op:     rd_val = alu_result_of(f3, insn[30], a, b);
    code_load: begin
      addr = a + imm_i;
      word = model_mem[addr[7:2]] >> (8 * addr[1:0]);
      case (f3)
        3'b000:  rd_val = {{24{word[7]}}, word[7:0]};
        3'b001:  rd_val = {{16{word[15]}}, word[15:0]};
        3'b100:  rd_val = {24'b0, word[7:0]};
        3'b101:  rd_val = {16'b0, word[15:0]};
        default: rd_val = word;
      endcase
    end
    code_store: begin
      wr = 1'b0;
      addr = a + imm_s;
      exp_addr = {addr[31:2], 2'b00};
      case (f3)
        3'b000:  exp_we = byte_en_t'(4'b0001 << addr[1:0]);
        3'b001:  exp_we = byte_en_t'(4'b0011 << addr[1:0]);
        default: exp_we = 4'b1111;
      endcase
      exp_data = b << (8 * addr[1:0]);
      for (int i = 0; i < `NUM_BYTE_LANES; i++) begin
        if (exp_we[i]) model_mem[addr[7:2]][8*i +: 8] = exp_data[8*i +: 8];
      end
    end
    code_branch: begin
      wr = 1'b0;
      case (f3)
        3'b000:  taken = (a == b);
        3'b001:  taken = (a != b);
        3'b100:  taken = ($signed(a) < $signed(b));
        3'b101:  taken = ($signed(a) >= $signed(b));
        3'b110:  taken = (a < b);
        3'b111:  taken = (a >= b);
        default: taken = 1'b0;
      endcase
      if (taken) exp_next_pc = model_pc + imm_b;
    end
    code_jal: begin
      rd_val = model_pc + 32'd4;
      exp_next_pc = model_pc + imm_j;
    end
    code_jalr: begin
      rd_val = model_pc + 32'd4;
      exp_next_pc = (a + imm_i) & ~32'd1;
    end
    code_system: begin
      wr = 1'b0;
      exp_halt = (insn[31:7] == '0);
    end
    default: wr = 1'b0;
  endcase
  if (wr && rd != 5'd0) model_regs[rd] = rd_val;
  model_pc = exp_next_pc;
endtask

`endif

/* tb_rv_core.sv */
`timescale 1ns/1ns
`include "core_config.svh"

module tb_rv_core
  import rv_isa_pkg::*;
();

  localparam int halt_timeout = 8;

  logic     clk;
  logic     rst;
  logic     halt;
  word_t    pc_to_imem;
  word_t    insn_from_imem;
  word_t    addr_to_dmem;
  word_t    store_data_to_dmem;
  word_t    load_data_from_dmem;
  byte_en_t store_we_to_dmem;

  // data memory seen by the DUT, 64 words
  word_t    dmem [64];

  integer   seed = 32'hbbfc_b5e0;
  int       errors = 0;
  int       checks = 0;
  int       tests_run = 0;
  int       tests_failed = 0;
  int       test_err_start;
  string    cur_test;

  `include "tb_rv_model.svh"

  rv_core u_dut (
    .clk                 (clk),
    .rst                 (rst),
    .halt                (halt),
    .pc_to_imem          (pc_to_imem),
    .insn_from_imem      (insn_from_imem),
    .addr_to_dmem        (addr_to_dmem),
    .store_data_to_dmem  (store_data_to_dmem),
    .load_data_from_dmem (load_data_from_dmem),
    .store_we_to_dmem    (store_we_to_dmem)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  assign load_data_from_dmem = dmem[addr_to_dmem[7:2]];

  always @(posedge clk) begin
    for (int i = 0; i < `NUM_BYTE_LANES; i++) begin
      if (store_we_to_dmem[i]) dmem[addr_to_dmem[7:2]][8*i +: 8] <= store_data_to_dmem[8*i +: 8];
    end
  end

  function automatic word_t next_random();
    return $random(seed);
  endfunction

  function automatic int unsigned pick(input int unsigned n);
    return $unsigned($random(seed)) % n;
  endfunction

  function automatic reg_addr_t any_reg();
    return reg_addr_t'(pick(32));
  endfunction

  function automatic reg_addr_t dest_reg();
    return reg_addr_t'(1 + pick(31));
  endfunction

  // instruction formats
  function automatic word_t r_type(input logic [6:0] f7, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input funct3_t f3, input reg_addr_t rd);
    return {f7, rs2, rs1, f3, rd, code_op};
  endfunction

  function automatic word_t i_type(input logic [11:0] imm, input reg_addr_t rs1,
                                   input funct3_t f3, input reg_addr_t rd, input logic [6:0] opc);
    return {imm, rs1, f3, rd, opc};
  endfunction

  function automatic word_t s_type(input logic [11:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input funct3_t f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], code_store};
  endfunction

  function automatic word_t b_type(input logic [12:0] imm, input reg_addr_t rs2,
                                   input reg_addr_t rs1, input funct3_t f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], code_branch};
  endfunction

  function automatic word_t u_type(input logic [19:0] imm, input reg_addr_t rd,
                                   input logic [6:0] opc);
    return {imm, rd, opc};
  endfunction

  function automatic word_t j_type(input logic [20:0] imm, input reg_addr_t rd);
    return {imm[20], imm[10:1], imm[11], imm[19:12], rd, code_jal};
  endfunction

  task automatic compare(input string what, input word_t expected, input word_t actual);
    checks++;
    if (expected !== actual) begin
      errors++;
      $display("ERROR %s: %s expected %08h actual %08h", cur_test, what, expected, actual);
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_start = errors;
  endtask

  task automatic report_test();
    tests_run++;
    if (errors != test_err_start) begin
      tests_failed++;
      $display("test %-12s failed with %0d mismatches", cur_test, errors - test_err_start);
    end else begin
      $display("test %-12s ok", cur_test);
    end
  endtask

  // entered just after a rising edge, leaves just after the next one
  task automatic run_insn(input string what, input word_t insn);
    word_t mask;
    compare({what, " pc"}, model_pc, pc_to_imem);
    execute_insn(insn);
    insn_from_imem = insn;
    #4;
    for (int i = 0; i < `NUM_BYTE_LANES; i++) begin
      mask[8*i +: 8] = {8{exp_we[i]}};
    end
    compare({what, " byte enables"}, word_t'(exp_we), word_t'(store_we_to_dmem));
    if (exp_we != '0) begin
      compare({what, " store addr"}, exp_addr, addr_to_dmem);
      compare({what, " store data"}, exp_data & mask, store_data_to_dmem & mask);
    end
    compare({what, " halt"}, word_t'(exp_halt), word_t'(halt));
    @(posedge clk);
    #1;
  endtask

  // word store of one register through x0 base
  task automatic expose_reg(input reg_addr_t r);
    run_insn("expose", s_type(12'(pick(64) * 4), r, 5'd0, 3'b010));
  endtask

  function automatic logic [11:0] aligned_offset(input logic [1:0] size);
    logic [11:0] off;
    off = 12'(pick(256));
    if (size == 2'b01) off[0] = 1'b0;
    if (size == 2'b10) off[1:0] = 2'b00;
    return off;
  endfunction

  initial begin
    word_t       w;
    reg_addr_t   rd;
    reg_addr_t   rs1;
    funct3_t     f3;
    logic [11:0] imm;
    logic        alt;
    int          waited;

    rst = 1'b1;
    insn_from_imem = 32'h0000_0013;
    for (int i = 0; i < 64; i++) begin
      dmem[i] = fill_word(i);
      model_mem[i] = fill_word(i);
    end
    for (int i = 0; i < `NUM_REGS; i++) begin
      model_regs[i] = '0;
    end

    start_test("reset");
    repeat (4) @(posedge clk);
    #1;
    rst = 1'b0;
    compare("pc", `RESET_PC, pc_to_imem);
    compare("byte enables", '0, word_t'(store_we_to_dmem));
    compare("halt", '0, word_t'(halt));
    model_pc = `RESET_PC;
    report_test();

    start_test("alu");
    // seed every register with a random value
    for (int r = 1; r < `NUM_REGS; r++) begin
      w = next_random();
      run_insn("lui", u_type(w[31:12], reg_addr_t'(r), code_lui));
      run_insn("addi", i_type(w[11:0], reg_addr_t'(r), 3'b000, reg_addr_t'(r), code_op_imm));
    end
    for (int n = 0; n < 60; n++) begin
      w = next_random();
      f3 = funct3_t'(pick(8));
      rd = (pick(8) == 0) ? 5'd0 : dest_reg();
      if (pick(2) == 1) begin
        alt = (f3 == 3'b000 || f3 == 3'b101) && pick(2) == 1;
        run_insn("reg-reg", r_type(alt ? 7'h20 : 7'h00, any_reg(), any_reg(), f3, rd));
      end else begin
        imm = w[11:0];
        if (f3 == 3'b001) imm[11:5] = 7'h00;
        if (f3 == 3'b101) imm[11:5] = (pick(2) == 1) ? 7'h20 : 7'h00;
        run_insn("reg-imm", i_type(imm, any_reg(), f3, rd, code_op_imm));
      end
      expose_reg(rd);
    end
    report_test();

    start_test("upper");
    for (int n = 0; n < 20; n++) begin
      w = next_random();
      rd = dest_reg();
      run_insn("upper", u_type(w[19:0], rd, (pick(2) == 1) ? code_lui : code_auipc));
      expose_reg(rd);
    end
    report_test();

    start_test("load_store");
    for (int n = 0; n < 30; n++) begin
      f3 = funct3_t'(pick(3));
      run_insn("store", s_type(aligned_offset(f3[1:0]), any_reg(), 5'd0, f3));
      // lb lh lw lbu lhu
      f3 = funct3_t'(pick(5));
      if (f3 > 3'd2) f3 = f3 + 3'd1;
      rd = dest_reg();
      run_insn("load", i_type(aligned_offset(f3[1:0]), 5'd0, f3, rd, code_load));
      expose_reg(rd);
    end
    report_test();

    start_test("control");
    for (int n = 0; n < 30; n++) begin
      w = next_random();
      rd = dest_reg();
      rs1 = any_reg();
      case (pick(4))
        0, 1: begin
          f3 = funct3_t'(pick(6));
          if (f3 > 3'd1) f3 = f3 + 3'd2;
          run_insn("branch", b_type({w[12:1], 1'b0}, (pick(4) == 0) ? rs1 : any_reg(), rs1, f3));
        end
        2: begin
          run_insn("jal", j_type({w[20:1], 1'b0}, rd));
          expose_reg(rd);
        end
        default: begin
          run_insn("jalr", i_type(w[11:0], rs1, 3'b000, rd, code_jalr));
          expose_reg(rd);
        end
      endcase
    end
    report_test();

    start_test("ecall");
    compare("ecall pc", model_pc, pc_to_imem);
    execute_insn(32'h0000_0073);
    insn_from_imem = 32'h0000_0073;
    waited = 0;
    while (!halt && waited < halt_timeout) begin
      #1;
      waited++;
    end
    if (!halt) begin
      $display("halt did not rise within %0d ns of ecall", halt_timeout);
      $display("TESTBENCH FAILED");
      $finish;
    end
    compare("ecall byte enables", '0, word_t'(store_we_to_dmem));
    report_test();

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

/* sources.f */
+incdir+.
rv_isa_pkg.sv
core_pkg.sv
reg_file.sv
insn_decoder.sv
alu.sv
lsu_align.sv
pc_unit.sv
rv_core.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - include_dirs:
      - .
    files:
      - rv_isa_pkg.sv
      - core_pkg.sv
      - reg_file.sv
      - insn_decoder.sv
      - alu.sv
      - lsu_align.sv
      - pc_unit.sv
      - rv_core.sv
  - target: simulation
    include_dirs:
      - .
    files:
      - tb_rv_core.sv
